// File: dv/smc_tb.sv
/*
 * Testbench for smc_veneer. Runs a table of APB and AHB steps against
 * an SRAM model on the pins and checks data, response and timing.
 */
`timescale 1ns/1ps

module smc_tb;

  localparam int         CLK_PERIOD = 8;
  localparam int         MEM_AW     = 16;
  localparam logic [1:0] K_APB_WR   = 2'd0;
  localparam logic [1:0] K_APB_RD   = 2'd1;
  localparam logic [1:0] K_AHB_WR   = 2'd2;   // Bit 1 marks AHB kinds
  localparam logic [1:0] K_AHB_RD   = 2'd3;

  // One row of the stimulus table
  typedef struct packed {
    logic [1:0]         kind;
    smc_pkg::ahb_addr_t addr;
    logic [2:0]         size;
    smc_pkg::ahb_data_t data;
    logic               rnd;        // Data drawn from $random
    smc_pkg::ahb_data_t exp_data;
    logic [1:0]         exp_resp;
    logic [7:0]         exp_low;    // hready low cycles
    smc_pkg::be_t       exp_be;     // Lanes of a good AHB row
  } step_t;

  logic               hclk, rst_n, hsel, hwrite, hready, smc_hready, smc_valid;
  logic [1:0]         htrans, smc_hresp;
  logic [2:0]         hsize;
  smc_pkg::ahb_addr_t haddr, smc_addr;
  smc_pkg::ahb_data_t hwdata, smc_hrdata, data_smc, smc_data, prdata, pwdata;
  logic               psel, penable, pwrite;
  smc_pkg::apb_addr_t paddr;
  smc_pkg::be_t       smc_n_be, smc_n_we;
  logic               smc_n_cs, smc_n_wr, smc_n_rd, smc_n_ext_oe, smc_busy;

  step_t  steps [32];
  int     n_steps    = 0;
  int     err_total  = 0;      // Failed checks so far
  integer seed       = 73;
  logic   setup_done = 1'b0;
  string  kind_name [4] = '{"apb_wr", "apb_rd", "ahb_wr", "ahb_rd"};

  assign hready = smc_hready;  // Only slave on the bus

  smc_veneer #(.MEM_AW(MEM_AW)) smc_veneer_i (.*);

  smc_tb_mem mem_i (
    .clk (hclk), .smc_addr, .smc_data, .smc_n_we, .smc_n_cs, .smc_n_wr, .smc_n_rd, .data_smc
  );

  initial begin
    hclk = 1'b0;
    forever #(CLK_PERIOD / 2) hclk = ~hclk;
  end

  // ----------------------------------------
  // Compare tasks
  // ----------------------------------------
  task automatic check_data(input string name, input smc_pkg::ahb_data_t got,
                            input smc_pkg::ahb_data_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s got 0x%h exp 0x%h", name, got, exp);
      err_total++;
    end
  endtask

  task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s got 0x%h exp 0x%h", name, got, exp);
      err_total++;
    end
  endtask

  task automatic check_lanes(input string name, input smc_pkg::be_t got,
                             input smc_pkg::be_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s got 0x%h exp 0x%h", name, got, exp);
      err_total++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s got 0x%h exp 0x%h", name, got, exp);
      err_total++;
    end
  endtask

  task automatic check_cycles(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("CHECK FAILED %s got 0x%0h exp 0x%0h", name, got, exp);
      err_total++;
    end
  endtask

  // ----------------------------------------
  // Stimulus table
  // ----------------------------------------
  task automatic add_step(input logic [1:0] kind, input smc_pkg::ahb_addr_t addr,
                          input logic [2:0] size, input logic rnd, input smc_pkg::ahb_data_t data);
    steps[n_steps] = '{kind, addr, size, data, rnd, '0, smc_pkg::HRESP_OKAY, 8'd0, '0};
    n_steps++;
  endtask

  task automatic build_table();
    add_step(K_APB_RD, smc_pkg::REG_TIMING, 3'd0, 1'b0, '0);   // Reset timing
    add_step(K_APB_RD, smc_pkg::REG_ACC_CNT, 3'd0, 1'b0, '0);
    add_step(K_APB_RD, smc_pkg::REG_ERR_CNT, 3'd0, 1'b0, '0);
    add_step(K_APB_WR, smc_pkg::REG_TIMING, 3'd0, 1'b0, 32'h00);   // No wait states
    add_step(K_APB_RD, smc_pkg::REG_TIMING, 3'd0, 1'b0, '0);
    add_step(K_AHB_WR, 32'h0000_0010, smc_pkg::HSIZE_WORD, 1'b1, '0);
    add_step(K_AHB_WR, 32'h0000_0011, smc_pkg::HSIZE_BYTE, 1'b1, '0);   // Lane 1
    add_step(K_AHB_WR, 32'h0000_0016, smc_pkg::HSIZE_HALF, 1'b1, '0);   // Upper half
    add_step(K_AHB_RD, 32'h0000_0010, smc_pkg::HSIZE_WORD, 1'b0, '0);
    add_step(K_AHB_RD, 32'h0000_0014, smc_pkg::HSIZE_WORD, 1'b0, '0);
    add_step(K_APB_WR, smc_pkg::REG_TIMING, 3'd0, 1'b0, 32'h33);
    add_step(K_AHB_WR, 32'h0000_0023, smc_pkg::HSIZE_BYTE, 1'b1, '0);   // Lane 3
    add_step(K_AHB_WR, 32'h0000_0020, smc_pkg::HSIZE_HALF, 1'b1, '0);   // Lower half
    add_step(K_AHB_RD, 32'h0000_0020, smc_pkg::HSIZE_WORD, 1'b0, '0);
    add_step(K_APB_WR, smc_pkg::REG_TIMING, 3'd0, 1'b0, 32'h77);
    add_step(K_AHB_WR, 32'h0000_0030, smc_pkg::HSIZE_WORD, 1'b1, '0);
    add_step(K_AHB_RD, 32'h0000_0030, smc_pkg::HSIZE_WORD, 1'b0, '0);
    add_step(K_AHB_WR, 32'h0001_0030, smc_pkg::HSIZE_WORD, 1'b1, '0);   // Bit 16 set
    add_step(K_APB_WR, smc_pkg::REG_CTRL, 3'd0, 1'b0, 32'h1);           // Write protect
    add_step(K_AHB_WR, 32'h0000_0030, smc_pkg::HSIZE_BYTE, 1'b1, '0);
    add_step(K_AHB_RD, 32'h0000_0030, smc_pkg::HSIZE_WORD, 1'b0, '0);   // Unchanged
    add_step(K_APB_RD, smc_pkg::REG_ACC_CNT, 3'd0, 1'b0, '0);
    add_step(K_APB_RD, smc_pkg::REG_ERR_CNT, 3'd0, 1'b0, '0);
    add_step(K_APB_RD, smc_pkg::REG_STATUS, 3'd0, 1'b0, '0);
  endtask

  // Draws random data and works out every expected value from a shadow
  // of the SRAM and of the register state
  task automatic compute_expect();
    smc_pkg::ahb_data_t shadow [64];
    smc_pkg::be_t       lanes;
    logic [3:0]         rd_w;
    logic [3:0]         wr_w;
    logic               wp;
    logic               bad;
    logic [4:0]         ra;
    logic [5:0]         wi;
    int                 good_cnt;
    int                 bad_cnt;
    rd_w = 4'd2;                  // Timing after reset
    wr_w = 4'd2;
    wp = 1'b0;
    good_cnt = 0;
    bad_cnt = 0;
    for (int i = 0; i < 64; i++) begin
      shadow[i] = {i[5:0], 2'b11, ~i[5:0], 2'b00, i[5:0], 2'b01, ~i[5:0], 2'b10};
    end
    for (int n = 0; n < n_steps; n++) begin
      if (steps[n].rnd) begin
        steps[n].data = $random(seed);
      end
      ra = steps[n].addr[4:0];
      wi = steps[n].addr[7:2];
      case (steps[n].kind)
        K_APB_WR: begin
          if (ra == smc_pkg::REG_TIMING) begin
            rd_w = steps[n].data[3:0];
            wr_w = steps[n].data[7:4];
          end
          if (ra == smc_pkg::REG_CTRL) begin
            wp = steps[n].data[0];
          end
        end
        K_APB_RD: begin
          case (ra)
            smc_pkg::REG_TIMING:  steps[n].exp_data = {24'b0, wr_w, rd_w};
            smc_pkg::REG_CTRL:    steps[n].exp_data = {31'b0, wp};
            smc_pkg::REG_ACC_CNT: steps[n].exp_data = good_cnt;
            smc_pkg::REG_ERR_CNT: steps[n].exp_data = bad_cnt;
            default:              steps[n].exp_data = '0;   // Idle, not busy
          endcase
        end
        default: begin
          bad = ((steps[n].addr >> MEM_AW) != 0) || (steps[n].kind == K_AHB_WR && wp);
          if (bad) begin
            steps[n].exp_resp = smc_pkg::HRESP_ERROR;
            steps[n].exp_low  = 8'd1;   // Then one ERROR cycle with hready high
            bad_cnt++;
          end else begin
            steps[n].exp_low = (steps[n].kind == K_AHB_WR ? wr_w : rd_w) + 8'd2;
            case (steps[n].size)
              smc_pkg::HSIZE_BYTE: lanes = smc_pkg::be_t'(4'b0001 << steps[n].addr[1:0]);
              smc_pkg::HSIZE_HALF: lanes = steps[n].addr[1] ? 4'b1100 : 4'b0011;
              default:             lanes = 4'b1111;
            endcase
            steps[n].exp_be = lanes;
            for (int b = 0; b < 4; b++) begin
              if (steps[n].kind == K_AHB_WR && lanes[b]) begin
                shadow[wi][8*b +: 8] = steps[n].data[8*b +: 8];   // AHB lane b
              end
            end
            steps[n].exp_data = shadow[wi];
            good_cnt++;
          end
        end
      endcase
    end
  endtask

  // ----------------------------------------
  // Bus drivers, inputs change on falling edges
  // ----------------------------------------
  task automatic apb_step(input step_t s, output smc_pkg::ahb_data_t rd);
    @(negedge hclk);              // Setup phase
    psel   = 1'b1;
    pwrite = (s.kind == K_APB_WR);
    paddr  = s.addr[4:0];
    pwdata = s.data;
    @(negedge hclk);              // Enable phase
    penable = 1'b1;
    rd = prdata;
    @(negedge hclk);
    {psel, penable, pwrite} = '0;
  endtask

  // Single transfer; hready low cycles counted from the data phase on
  task automatic ahb_step(input step_t s);
    int         low;
    int         wr0;
    int         rd0;
    int         exp_strb;
    logic [1:0] first_resp;
    wr0 = mem_i.wr_strobe_cnt;
    rd0 = mem_i.rd_strobe_cnt;
    exp_strb = (s.exp_resp == smc_pkg::HRESP_OKAY) ? int'(s.exp_low) - 1 : 0;
    @(negedge hclk);              // Address phase
    hsel   = 1'b1;
    haddr  = s.addr;
    htrans = smc_pkg::HTRANS_NONSEQ;
    hwrite = (s.kind == K_AHB_WR);
    hsize  = s.size;
    #1;
    if (!smc_valid) begin
      $display("Address phase at 0x%h was not flagged by smc_valid", s.addr);
      err_total++;
    end
    @(negedge hclk);              // Data phase
    hsel   = 1'b0;
    htrans = smc_pkg::HTRANS_IDLE;
    hwdata = s.data;
    first_resp = smc_hresp;
    low = 0;
    while (!smc_hready && low < 40) begin
      low++;
      if (!smc_n_cs) begin        // Strobe cycle of this access
        check_lanes("smc_n_be", smc_n_be, ~s.exp_be);
        check_bit("smc_n_ext_oe", smc_n_ext_oe, s.kind != K_AHB_WR);
        check_bit("smc_busy", smc_busy, 1'b1);
      end
      @(negedge hclk);
    end
    if (!smc_hready) begin
      $display("Transfer at 0x%h still stalled after 40 cycles", s.addr);
      err_total++;
    end
    check_cycles("hready low cycles", low, s.exp_low);
    check_resp("smc_hresp stall", first_resp, s.exp_resp);
    check_resp("smc_hresp", smc_hresp, s.exp_resp);
    check_bit("smc_busy", smc_busy, 1'b0);   // Sequencer back in idle
    if (s.kind == K_AHB_RD && s.exp_resp == smc_pkg::HRESP_OKAY) begin
      check_data("smc_hrdata", smc_hrdata, s.exp_data);
    end
    // SRAM sees one strobe cycle fewer than the stall
    check_cycles("write strobe cycles", mem_i.wr_strobe_cnt - wr0,
                 (s.kind == K_AHB_WR) ? exp_strb : 0);
    check_cycles("read strobe cycles", mem_i.rd_strobe_cnt - rd0,
                 (s.kind == K_AHB_RD) ? exp_strb : 0);
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin
    smc_pkg::ahb_data_t rd;
    int                 errs_before;
    int                 pass_cnt;
    int                 fail_cnt;
    logic               ok;
    rst_n = 1'b0;
    {hsel, hwrite, psel, penable, pwrite} = '0;
    htrans = smc_pkg::HTRANS_IDLE;
    hsize  = smc_pkg::HSIZE_WORD;
    haddr  = '0;
    hwdata = '0;
    paddr  = '0;
    pwdata = '0;
    pass_cnt = 0;
    fail_cnt = 0;
    build_table();
    compute_expect();
    setup_done = 1'b1;
    repeat (3) @(posedge hclk);   // Reset over three edges
    @(negedge hclk);
    rst_n = 1'b1;
    for (int n = 0; n < n_steps; n++) begin
      errs_before = err_total;
      if (steps[n].kind[1]) begin
        ahb_step(steps[n]);
      end else begin
        apb_step(steps[n], rd);
        if (steps[n].kind == K_APB_RD) begin
          check_data("prdata", rd, steps[n].exp_data);
        end
      end
      ok = (err_total == errs_before);
      if (ok) begin
        pass_cnt++;
      end else begin
        fail_cnt++;
      end
      $display("Step %0d %s 0x%h %s", n, kind_name[steps[n].kind], steps[n].addr,
               ok ? "ok" : "failed");
    end
    $display("Steps passed %0d failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // Watchdog sized from the table, 19 cycles per step plus margin
  initial begin
    wait (setup_done);
    #(n_steps * (15 + 4) * CLK_PERIOD + 400);
    $display("Watchdog expired before the step table finished");
    $display("TB FAILED");
    $finish;
  end

endmodule

// File: dv/smc_tb_mem.sv
/*
 * Behavioral asynchronous SRAM on the controller pins. 64 words picked
 * by address bits 7:2, byte lane writes, strobe cycles counted.
 */
`timescale 1ns/1ps

module smc_tb_mem (
  input  logic               clk,
  input  smc_pkg::ahb_addr_t smc_addr,
  input  smc_pkg::ahb_data_t smc_data,
  input  smc_pkg::be_t       smc_n_we,   // Lane write strobes, low active
  input  logic               smc_n_cs,
  input  logic               smc_n_wr,
  input  logic               smc_n_rd,
  output smc_pkg::ahb_data_t data_smc
);

  smc_pkg::ahb_data_t mem [64];
  int                 wr_strobe_cnt = 0;   // Write strobe cycles seen
  int                 rd_strobe_cnt = 0;   // Read strobe cycles seen
  logic [5:0]         idx;

  assign idx = smc_addr[7:2];

  // Read data only while the read strobe is low
  assign data_smc = (!smc_n_cs && !smc_n_rd) ? mem[idx] : '0;

  // Power-up contents built from the whole word index
  initial begin
    for (int i = 0; i < 64; i++) begin
      mem[i] = {i[5:0], 2'b11, ~i[5:0], 2'b00, i[5:0], 2'b01, ~i[5:0], 2'b10};
    end
  end

  // ----------------------------------------
  // Strobes come from flops, so each rising edge sees the cycle just ended
  always @(posedge clk) begin
    if (!smc_n_cs && !smc_n_wr) begin
      wr_strobe_cnt <= wr_strobe_cnt + 1;
      for (int b = 0; b < 4; b++) begin
        if (!smc_n_we[b]) begin
          mem[idx][8*b +: 8] <= smc_data[8*b +: 8];   // Merge this lane only
        end
      end
    end
    if (!smc_n_cs && !smc_n_rd) begin
      rd_strobe_cnt <= rd_strobe_cnt + 1;
    end
  end

endmodule

// File: hdl/smc_ahb_if.sv
/*
 * AHB-lite slave front end. Captures single transfers, decodes byte
 * lanes, answers errors itself and issues one EMI request per good
 * transfer, holding hready low until the sequencer reports done.
 */
`timescale 1ns/1ps

module smc_ahb_if #(
  parameter int MEM_AW = 16     // External address width in bits
) (
  input  logic                hclk,
  input  logic                rst_n,
  input  logic                hsel,
  input  smc_pkg::ahb_addr_t  haddr,
  input  logic [1:0]          htrans,
  input  logic                hwrite,
  input  logic [2:0]          hsize,
  input  smc_pkg::ahb_data_t  hwdata,
  input  logic                hready,      // Muxed bus ready
  input  smc_pkg::smc_cfg_t   cfg,
  input  logic                done,        // Sequencer finished
  input  smc_pkg::ahb_data_t  rdata,
  output smc_pkg::ahb_data_t  smc_hrdata,
  output logic                smc_hready,
  output logic [1:0]          smc_hresp,
  output logic                smc_valid,
  output logic                req_valid,
  output smc_pkg::emi_req_t   req,
  output logic                err_pulse
);

  logic               accept;      // Address phase taken at this edge
  logic               acc_err;     // That address phase is an error
  smc_pkg::be_t       lanes;       // Decoded lanes of the address phase
  smc_pkg::ahb_addr_t addr_q;
  smc_pkg::be_t       be_q;
  logic               write_q;
  logic               pending;     // Good transfer waiting for done
  logic               err_phase;   // First cycle of error response

  // ----------------------------------------
  // Address phase decode
  // ----------------------------------------
  assign smc_valid = hsel && hready &&
                     (htrans == smc_pkg::HTRANS_NONSEQ || htrans == smc_pkg::HTRANS_SEQ);
  assign accept    = smc_valid;

  // Out of range address, or write under protection
  assign acc_err = (|(haddr >> MEM_AW)) || (hwrite && cfg.wr_protect);

  always_comb begin
    case (hsize)
      smc_pkg::HSIZE_BYTE: lanes = smc_pkg::be_t'(4'b0001 << haddr[1:0]);
      smc_pkg::HSIZE_HALF: lanes = haddr[1] ? 4'b1100 : 4'b0011;
      smc_pkg::HSIZE_WORD: lanes = 4'b1111;
      default:             lanes = 4'b1111;   // Wider sizes treated as word
    endcase
  end

  // Payload of the accepted address phase
  always_ff @(posedge hclk) begin
    if (accept) begin
      addr_q  <= {haddr[31:2], 2'b00};   // Word aligned
      be_q    <= lanes;
      write_q <= hwrite;
    end
  end

  // Write data is the live data phase value
  assign req = '{addr: addr_q, wdata: hwdata, be: be_q, write: write_q};

  // ----------------------------------------
  // Response control
  // ----------------------------------------
  always_ff @(posedge hclk) begin
    if (!rst_n) begin
      smc_hready <= 1'b1;
      smc_hresp  <= smc_pkg::HRESP_OKAY;
      req_valid  <= 1'b0;
      pending    <= 1'b0;
      err_phase  <= 1'b0;
    end else begin
      req_valid <= 1'b0;   // One cycle pulse
      err_phase <= 1'b0;
      if (accept) begin
        smc_hready <= 1'b0;
        if (acc_err) begin
          smc_hresp <= smc_pkg::HRESP_ERROR;   // No request issued
          err_phase <= 1'b1;
        end else begin
          smc_hresp <= smc_pkg::HRESP_OKAY;
          req_valid <= 1'b1;
          pending   <= 1'b1;
        end
      end else if (err_phase) begin
        smc_hready <= 1'b1;                    // Second ERROR cycle
      end else if (pending && done) begin
        smc_hready <= 1'b1;
        pending    <= 1'b0;
      end else if (smc_hready) begin
        smc_hresp <= smc_pkg::HRESP_OKAY;      // Back to OKAY after error
      end
    end
  end

  // Read data captured with the closing edge
  always_ff @(posedge hclk) begin
    if (pending && done && !write_q) begin
      smc_hrdata <= rdata;
    end
  end

  assign err_pulse = err_phase;   // Once per error transfer

  // ----------------------------------------
  // Assertions
  // ----------------------------------------
  // New request only after the previous transfer has closed
  a_no_req_overlap : assert property (@(posedge hclk) disable iff (!rst_n)
    req_valid |-> !$past(pending));

  // Two cycle error response
  a_err_two_cycle : assert property (@(posedge hclk) disable iff (!rst_n)
    (smc_hready && smc_hresp == smc_pkg::HRESP_ERROR) |->
    $past(!smc_hready && smc_hresp == smc_pkg::HRESP_ERROR));

endmodule

// File: hdl/smc_apb_regs.sv
/*
 * APB register block on hclk with zero wait states. Holds strobe
 * timing and write protect, plus saturating access and error counters.
 */
`timescale 1ns/1ps

module smc_apb_regs (
  input  logic                hclk,
  input  logic                rst_n,
  input  logic                psel,
  input  logic                penable,
  input  logic                pwrite,
  input  smc_pkg::apb_addr_t  paddr,
  input  smc_pkg::ahb_data_t  pwdata,
  input  logic                done,        // Access completed
  input  logic                err_pulse,   // Error response issued
  input  logic                busy,
  output smc_pkg::ahb_data_t  prdata,
  output smc_pkg::smc_cfg_t   cfg
);

  logic          wr_en;     // APB write strobe
  smc_pkg::cnt_t acc_cnt;
  smc_pkg::cnt_t err_cnt;

  assign wr_en = psel && penable && pwrite;

  // ----------------------------------------
  // Timing and control
  // ----------------------------------------
  always_ff @(posedge hclk) begin
    if (!rst_n) begin
      cfg.rd_wait    <= smc_pkg::RST_RD_WAIT;
      cfg.wr_wait    <= smc_pkg::RST_WR_WAIT;
      cfg.wr_protect <= 1'b0;
    end else if (wr_en) begin
      if (paddr == smc_pkg::REG_TIMING) begin
        cfg.rd_wait <= pwdata[3:0];
        cfg.wr_wait <= pwdata[7:4];
      end
      if (paddr == smc_pkg::REG_CTRL) begin
        cfg.wr_protect <= pwdata[0];
      end
    end
  end

  // ----------------------------------------
  // Status counters
  // ----------------------------------------
  always_ff @(posedge hclk) begin
    if (!rst_n) begin
      acc_cnt <= '0;
      err_cnt <= '0;
    end else begin
      if (wr_en && paddr == smc_pkg::REG_ACC_CNT) begin
        acc_cnt <= '0;                     // Any write clears
      end else if (done && acc_cnt != '1) begin
        acc_cnt <= acc_cnt + 1'b1;         // Saturates at all ones
      end
      if (wr_en && paddr == smc_pkg::REG_ERR_CNT) begin
        err_cnt <= '0;
      end else if (err_pulse && err_cnt != '1) begin
        err_cnt <= err_cnt + 1'b1;
      end
    end
  end

  // Read mux, zero when not selected
  always_comb begin
    prdata = '0;
    if (psel) begin
      case (paddr)
        smc_pkg::REG_TIMING:  prdata = {24'b0, cfg.wr_wait, cfg.rd_wait};
        smc_pkg::REG_CTRL:    prdata = {31'b0, cfg.wr_protect};
        smc_pkg::REG_ACC_CNT: prdata = {16'b0, acc_cnt};
        smc_pkg::REG_ERR_CNT: prdata = {16'b0, err_cnt};
        smc_pkg::REG_STATUS:  prdata = {31'b0, busy};
        default:              prdata = '0;
      endcase
    end
  end

  // Enable phase always inside a select
  a_penable_psel : assert property (@(posedge hclk) disable iff (!rst_n)
    penable |-> psel);

endmodule

// File: hdl/smc_emi_fsm.sv
/*
 * External memory sequencer. Latches one request, drives the active
 * low SRAM strobes for wait+1 cycles and reports done in the last
 * strobe cycle, with read data valid alongside.
 */
`timescale 1ns/1ps

module smc_emi_fsm #(
  parameter int MEM_AW = 16     // External address width in bits
) (
  input  logic                hclk,
  input  logic                rst_n,
  input  logic                req_valid,
  input  smc_pkg::emi_req_t   req,
  input  smc_pkg::smc_cfg_t   cfg,
  input  smc_pkg::ahb_data_t  data_smc,    // SRAM read data
  output logic                done,
  output smc_pkg::ahb_data_t  rdata,
  output smc_pkg::ahb_addr_t  smc_addr,
  output smc_pkg::ahb_data_t  smc_data,
  output smc_pkg::be_t        smc_n_be,
  output smc_pkg::be_t        smc_n_we,
  output logic                smc_n_cs,
  output logic                smc_n_wr,
  output logic                smc_n_rd,
  output logic                smc_n_ext_oe,
  output logic                busy
);

  // Only address bits below MEM_AW reach the pins
  localparam smc_pkg::ahb_addr_t ADDR_MASK =
    smc_pkg::ahb_addr_t'((64'd1 << MEM_AW) - 64'd1);

  smc_pkg::emi_state_e state;
  smc_pkg::wait_t      wait_cnt;   // Strobe cycles left before LATCH
  smc_pkg::wait_t      req_wait;   // Wait states for the new request
  logic                start;      // Request taken this edge
  logic                wr_q;       // Direction of current access

  assign start    = (state == smc_pkg::IDLE) && req_valid;
  assign req_wait = req.write ? cfg.wr_wait : cfg.rd_wait;   // cfg sampled here

  // ----------------------------------------
  // State and wait counter
  // ----------------------------------------
  always_ff @(posedge hclk) begin
    if (!rst_n) begin
      state    <= smc_pkg::IDLE;
      wait_cnt <= '0;
    end else begin
      case (state)
        smc_pkg::IDLE: begin
          if (req_valid) begin
            if (req_wait == '0) begin
              state <= smc_pkg::LATCH;   // Single strobe cycle
            end else begin
              state    <= smc_pkg::STROBE;
              wait_cnt <= req_wait - 1'b1;
            end
          end
        end
        smc_pkg::STROBE: begin
          if (wait_cnt == '0) begin
            state <= smc_pkg::LATCH;
          end else begin
            wait_cnt <= wait_cnt - 1'b1;
          end
        end
        smc_pkg::LATCH: state <= smc_pkg::IDLE;
        default:        state <= smc_pkg::IDLE;
      endcase
    end
  end

  // ----------------------------------------
  // Strobes, all straight from flops
  // ----------------------------------------
  always_ff @(posedge hclk) begin
    if (!rst_n) begin
      smc_n_cs     <= 1'b1;
      smc_n_be     <= '1;
      smc_n_we     <= '1;
      smc_n_rd     <= 1'b1;
      smc_n_wr     <= 1'b1;
      smc_n_ext_oe <= 1'b1;
    end else if (start) begin
      smc_n_cs     <= 1'b0;
      smc_n_be     <= ~req.be;
      smc_n_we     <= req.write ? ~req.be : '1;   // Lane write strobes
      smc_n_rd     <= req.write;
      smc_n_wr     <= ~req.write;
      smc_n_ext_oe <= ~req.write;                 // Drive bus on writes
    end else if (state == smc_pkg::LATCH) begin
      smc_n_cs     <= 1'b1;
      smc_n_be     <= '1;
      smc_n_we     <= '1;
      smc_n_rd     <= 1'b1;
      smc_n_wr     <= 1'b1;
      smc_n_ext_oe <= 1'b1;
    end
  end

  // Address and write data held for the whole access
  always_ff @(posedge hclk) begin
    if (start) begin
      smc_addr <= req.addr & ADDR_MASK;
      smc_data <= req.wdata;
      wr_q     <= req.write;
    end
  end

  // ----------------------------------------
  // Completion
  // ----------------------------------------
  assign done  = (state == smc_pkg::LATCH);      // Last strobe cycle
  assign rdata = wr_q ? '0 : data_smc;           // Taken at end of LATCH
  assign busy  = (state != smc_pkg::IDLE);

  // Requests only come when the sequencer is free
  a_req_in_idle : assert property (@(posedge hclk) disable iff (!rst_n)
    req_valid |-> state == smc_pkg::IDLE);

  // Read and write strobes are exclusive
  a_rd_wr_excl : assert property (@(posedge hclk) disable iff (!rst_n)
    !(!smc_n_rd && !smc_n_wr));

endmodule

// File: hdl/smc_pkg.sv
/*
 * Shared types and constants for the static memory controller.
 * Every block refers to these by scoped name, smc_pkg::name.
 */
package smc_pkg;

  // ----------------------------------------
  // Widths with a meaning
  // ----------------------------------------
  typedef logic [31:0] ahb_addr_t;   // AHB byte address
  typedef logic [31:0] ahb_data_t;   // AHB and EMI data word
  typedef logic [3:0]  be_t;         // Byte lanes, active high inside
  typedef logic [3:0]  wait_t;       // Strobe wait states
  typedef logic [4:0]  apb_addr_t;   // APB register offset
  typedef logic [15:0] cnt_t;        // Status counter

  // One EMI access as handed from the AHB side to the sequencer
  typedef struct packed {
    ahb_addr_t addr;    // Word aligned byte address
    ahb_data_t wdata;   // Write data, live hwdata
    be_t       be;      // Lanes to access
    logic      write;   // 1 for write
  } emi_req_t;

  // Live configuration from the register block
  typedef struct packed {
    wait_t rd_wait;
    wait_t wr_wait;
    logic  wr_protect;
  } smc_cfg_t;

  // Sequencer states
  typedef enum logic [1:0] {
    IDLE,     // Strobes high, waiting for a request
    STROBE,   // Strobes low, counting wait states
    LATCH     // Last strobe cycle, read data sampled
  } emi_state_e;

  // ----------------------------------------
  // AHB encodings
  // ----------------------------------------
  localparam logic [1:0] HTRANS_IDLE   = 2'b00;
  localparam logic [1:0] HTRANS_BUSY   = 2'b01;
  localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
  localparam logic [1:0] HTRANS_SEQ    = 2'b11;

  localparam logic [1:0] HRESP_OKAY  = 2'b00;
  localparam logic [1:0] HRESP_ERROR = 2'b01;

  localparam logic [2:0] HSIZE_BYTE = 3'b000;
  localparam logic [2:0] HSIZE_HALF = 3'b001;
  localparam logic [2:0] HSIZE_WORD = 3'b010;

  // APB register map
  localparam apb_addr_t REG_TIMING  = 5'h00;   // rd_wait 3:0, wr_wait 7:4
  localparam apb_addr_t REG_CTRL    = 5'h04;   // wr_protect in bit 0
  localparam apb_addr_t REG_ACC_CNT = 5'h08;   // Completed accesses
  localparam apb_addr_t REG_ERR_CNT = 5'h0C;   // Error responses
  localparam apb_addr_t REG_STATUS  = 5'h10;   // busy in bit 0

  // Timing after reset
  localparam wait_t RST_RD_WAIT = 4'd2;
  localparam wait_t RST_WR_WAIT = 4'd2;

endpackage

// File: hdl/smc_veneer.sv
/*
 * Static memory controller top level. Connects the AHB front end,
 * the EMI sequencer and the APB registers to the outside pins.
 */
`timescale 1ns/1ps

module smc_veneer #(
  parameter int MEM_AW = 16     // External address width in bits
) (
  input  logic                hclk,
  input  logic                rst_n,
  // AHB slave
  input  logic                hsel,
  input  smc_pkg::ahb_addr_t  haddr,
  input  logic [1:0]          htrans,
  input  logic                hwrite,
  input  logic [2:0]          hsize,
  input  smc_pkg::ahb_data_t  hwdata,
  input  logic                hready,
  output smc_pkg::ahb_data_t  smc_hrdata,
  output logic                smc_hready,
  output logic [1:0]          smc_hresp,
  output logic                smc_valid,
  // APB registers
  input  logic                psel,
  input  logic                penable,
  input  logic                pwrite,
  input  smc_pkg::apb_addr_t  paddr,
  input  smc_pkg::ahb_data_t  pwdata,
  output smc_pkg::ahb_data_t  prdata,
  // External SRAM, strobes active low
  input  smc_pkg::ahb_data_t  data_smc,
  output smc_pkg::ahb_addr_t  smc_addr,
  output smc_pkg::ahb_data_t  smc_data,
  output smc_pkg::be_t        smc_n_be,
  output smc_pkg::be_t        smc_n_we,
  output logic                smc_n_cs,
  output logic                smc_n_wr,
  output logic                smc_n_rd,
  output logic                smc_n_ext_oe,
  output logic                smc_busy
);

  logic               req_valid;   // AHB side to sequencer
  smc_pkg::emi_req_t  req;
  logic               done;        // Sequencer back to AHB side
  smc_pkg::ahb_data_t rdata;
  smc_pkg::smc_cfg_t  cfg;         // Live timing and protect
  logic               err_pulse;

  smc_ahb_if #(.MEM_AW(MEM_AW)) smc_ahb_if_i (
    .hclk, .rst_n, .hsel, .haddr, .htrans, .hwrite, .hsize, .hwdata, .hready,
    .cfg, .done, .rdata,
    .smc_hrdata, .smc_hready, .smc_hresp, .smc_valid,
    .req_valid, .req, .err_pulse
  );

  smc_emi_fsm #(.MEM_AW(MEM_AW)) smc_emi_fsm_i (
    .hclk, .rst_n, .req_valid, .req, .cfg, .data_smc,
    .done, .rdata, .smc_addr, .smc_data, .smc_n_be, .smc_n_we,
    .smc_n_cs, .smc_n_wr, .smc_n_rd, .smc_n_ext_oe,
    .busy (smc_busy)
  );

  smc_apb_regs smc_apb_regs_i (
    .hclk, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata,
    .done, .err_pulse,
    .busy (smc_busy),
    .prdata, .cfg
  );

endmodule

// File: src.f
hdl/smc_pkg.sv
hdl/smc_ahb_if.sv
hdl/smc_emi_fsm.sv
hdl/smc_apb_regs.sv
hdl/smc_veneer.sv
dv/smc_tb_mem.sv
dv/smc_tb.sv
